/* test/prog.hex */
// One 32-bit word per entry, stored byte-swapped the way the fabric swaps it on fetch
// Word 0 holds the key routine (load key, store console, mret), RAM from word 0x40 holds no-ops
@0
FFFFFFFF 7FFFFFFF 00000000 13000000 13000000
@40
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000
13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000 13000000

/* files.f */
rtl/soc_pkg.sv
rtl/key_irq_ctrl.sv
rtl/bus_fabric.sv
rtl/tiny_core.sv
rtl/soc_top.sv
test/soc_chk.sv
test/soc_tb.sv

/* Bender.yml */
package:
  name: key_console_soc

sources:
  - files:
      - rtl/soc_pkg.sv
      - rtl/key_irq_ctrl.sv
      - rtl/bus_fabric.sv
      - rtl/tiny_core.sv
      - rtl/soc_top.sv
  - target: test
    files:
      - test/soc_chk.sv
      - test/soc_tb.sv

/* test/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb
    import soc_pkg::*;
();

    logic       CLOCK_50;
    logic       KEY0;
    key_t       key_code;
    logic       key_down;
    key_t       console_data;
    logic       console_valid;
    logic       irq_led;
    logic       heartbeat;
    logic [5:0] pc_leds;

    // Keyboard model state
    key_t        last_accepted;
    logic        model_down;
    logic        model_held;
    int          expected_pulses;
    int          pulse_count;
    logic [31:0] rng_state;

    soc_top dut0 (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .key_code      (key_code),
        .key_down      (key_down),
        .console_data  (console_data),
        .console_valid (console_valid),
        .irq_led       (irq_led),
        .heartbeat     (heartbeat),
        .pc_leds       (pc_leds)
    );

    // 100 ns clock
    always #50 CLOCK_50 = ~CLOCK_50;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Press rule: rising edge, nonzero code, no unreleased press
    function automatic logic press_accepted(input logic was_down, input logic held,
                                            input key_t code, input logic down);
        return down && !was_down && (code != 8'd0) && !held;
    endfunction

    // Console byte expected for the next pulse
    function automatic key_t expected_console();
        return last_accepted;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TEST FAIL");
        $fatal(1, "Wait timed out");
    endtask

    // Rising edge plus drive delay
    task automatic next_cycle();
        @(posedge CLOCK_50);
        #5;
    endtask

    // Drive one key sample and update the model
    task automatic drive_key(input key_t code, input logic down);
        next_cycle();
        key_code = code;
        key_down = down;
        if (press_accepted(model_down, model_held, code, down)) begin
            last_accepted = code;
            model_held = 1'b1;
            expected_pulses++;
        end
        // Release re-arms the model
        if (!down) begin
            model_held = 1'b0;
        end
        model_down = down;
    endtask

    // Nonzero random code
    task automatic draw_code(output key_t code);
        code = 8'd0;
        while (code == 8'd0) begin
            rng_state = xorshift32(rng_state);
            code = rng_state[7:0];
        end
    endtask

    task automatic wait_irq_led(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (irq_led !== level && n < limit) begin
            next_cycle();
            n++;
        end
        if (irq_led !== level) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_pulses(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (pulse_count < target && n < limit) begin
            next_cycle();
            n++;
        end
        if (pulse_count < target) begin
            report_timeout(what);
        end
    endtask

    // No request and no console pulse over a window
    task automatic check_quiet(input int cycles, input string what);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            check_equal({what, ", irq_led"}, irq_led, 1'b0);
            check_equal({what, ", console pulses"}, pulse_count, expected_pulses);
        end
    endtask

    task automatic press_and_release(input key_t code, input int hold);
        drive_key(code, 1'b1);
        wait_irq_led(1'b1, 5, "irq_led did not rise after a key press");
        // Ack drops the request before the routine stores
        wait_irq_led(1'b0, 40, "irq_led was not cleared by the acknowledge");
        check_equal("pulse before irq_led fell", pulse_count, expected_pulses - 1);
        wait_pulses(expected_pulses, 60, "no console pulse after a key press");
        repeat (hold) next_cycle();
        drive_key(code, 1'b0);
        repeat (5) next_cycle();
    endtask

    // Compares every console pulse, sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (KEY0 === 1'b1 && console_valid === 1'b1) begin
            pulse_count++;
            check_equal("console_data", console_data, expected_console());
            check_equal("irq_led at console pulse", irq_led, 1'b0);
            check_equal("console pulse count", pulse_count, expected_pulses);
        end
    end

    initial begin
        key_t       code;
        key_t       next_code;
        int         changes;
        logic [5:0] last_leds;
        logic       last_beat;
        CLOCK_50        = 1'b0;
        KEY0            = 1'b0;
        key_code        = 8'd0;
        key_down        = 1'b0;
        last_accepted   = 8'd0;
        model_down      = 1'b0;
        model_held      = 1'b0;
        expected_pulses = 0;
        pulse_count     = 0;
        rng_state       = 32'd95;

        repeat (10) @(posedge CLOCK_50);
        #5;
        KEY0 = 1'b1;

        // Idle after reset
        check_quiet(50, "idle after reset");

        // Random presses, one pulse each
        for (int i = 0; i < 20; i++) begin
            draw_code(code);
            press_and_release(code, 10);
        end

        // Zero code is never accepted
        drive_key(8'd0, 1'b1);
        check_quiet(200, "key code 0 press");
        drive_key(8'd0, 1'b0);
        repeat (5) next_cycle();

        // Long hold, then a code change while still down
        draw_code(code);
        next_code = code;
        while (next_code == code) begin
            draw_code(next_code);
        end
        drive_key(code, 1'b1);
        wait_pulses(expected_pulses, 60, "no console pulse for the held key");
        check_quiet(150, "key held");
        drive_key(next_code, 1'b1);
        check_quiet(150, "code changed while held");
        drive_key(next_code, 1'b0);
        repeat (5) next_cycle();
        press_and_release(next_code, 10);

        // Main program still advancing after mret
        last_leds = pc_leds;
        last_beat = heartbeat;
        changes = 0;
        for (int i = 0; i < 100; i++) begin
            next_cycle();
            check_equal("pulse without a press", pulse_count, expected_pulses);
            // Heartbeat flips on every clock
            check_equal("heartbeat toggle", heartbeat, !last_beat);
            if (pc_leds != last_leds) begin
                changes++;
            end
            last_leds = pc_leds;
            last_beat = heartbeat;
        end
        check_equal("pc_leds changes", changes, 100);

        if (pulse_count == expected_pulses) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("FAIL at %0t ns: %0d console pulses, expected %0d", $time,
                     pulse_count, expected_pulses);
            $display("TEST FAIL");
            $fatal(1, "Pulse count mismatch");
        end
    end

endmodule

/* test/soc_chk.sv */
`timescale 1ns/1ps

module soc_chk (
    input logic CLOCK_50,
    input logic KEY0,
    input logic pulse,
    input logic read_enable,
    input logic write_enable
);

    // Strobe of the bound module is one cycle wide
    single_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        pulse |=> !pulse)
        else $error("%m: strobe high for two cycles");

    // Read and write never share a cycle
    bus_exclusive: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(read_enable && write_enable))
        else $error("%m: bus read and write strobes high together");

    // Strobes leave reset low
    strobes_low: assert property (@(posedge CLOCK_50) $rose(KEY0) |->
        !pulse && !read_enable && !write_enable)
        else $error("%m: strobe high right after reset");

endmodule

// Interrupt acknowledge in the core
bind tiny_core soc_chk chk_core (
    .CLOCK_50     (CLOCK_50),
    .KEY0         (KEY0),
    .pulse        (irq_ack),
    .read_enable  (bus_read_enable),
    .write_enable (bus_write_enable)
);

// Console pulse in the fabric
bind bus_fabric soc_chk chk_fabric (
    .CLOCK_50     (CLOCK_50),
    .KEY0         (KEY0),
    .pulse        (console_valid),
    .read_enable  (bus_read_enable),
    .write_enable (bus_write_enable)
);

/* rtl/soc_top.sv */
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  key_t       key_code,
    input  logic       key_down,
    output key_t       console_data,
    output logic       console_valid,
    output logic       irq_led,
    output logic       heartbeat,
    output logic [5:0] pc_leds
);

    // Fetch path
    wire xlen_t pc;
    wire word_t instr;

    // Data bus
    wire xlen_t bus_address;
    wire xlen_t bus_write_data;
    wire xlen_t bus_read_data;
    wire        bus_read_enable;
    wire        bus_write_enable;

    // Interrupt and key port
    wire vec_t  irq_vector;
    wire        irq_ack;
    wire key_t  key_data;

    // Word index of pc on the LEDs
    assign pc_leds = pc[7:2];

    tiny_core core0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .instr            (instr),
        .irq_vector       (irq_vector),
        .bus_read_data    (bus_read_data),
        .pc               (pc),
        .irq_ack          (irq_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .heartbeat        (heartbeat)
    );

    bus_fabric fabric0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .pc               (pc),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .key_data         (key_data),
        .instr            (instr),
        .bus_read_data    (bus_read_data),
        .console_data     (console_data),
        .console_valid    (console_valid)
    );

    key_irq_ctrl kic0 (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_code   (key_code),
        .key_down   (key_down),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .key_data   (key_data),
        .irq_led    (irq_led)
    );

endmodule

/* rtl/tiny_core.sv */
`timescale 1ns/1ps

module tiny_core
    import soc_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  word_t instr,
    input  vec_t  irq_vector,
    input  xlen_t bus_read_data,
    output xlen_t pc,
    output logic  irq_ack,
    output xlen_t bus_address,
    output xlen_t bus_write_data,
    output logic  bus_read_enable,
    output logic  bus_write_enable,
    output logic  heartbeat
);

    // Instruction register, two cycles behind pc
    word_t       ir;
    // Register file, only x5 is written by this ISA
    xlen_t       regs [32];
    // Return address for mret
    xlen_t       mepc;
    logic        in_routine;
    core_state_t state;

    xlen_t pc_next;
    logic  take_irq;
    logic  exec;
    logic  is_load;
    logic  is_store;
    logic  is_mret;

    // Sequential pc, wraps from last RAM word to RAM base
    assign pc_next = (pc >= ram_base + ram_size - 64'd4) ? ram_base : pc + 64'd4;

    // Interrupt only from st_run and never nested
    assign take_irq = (state == st_run) && (irq_vector == key_vec) && !in_routine;
    // Interrupt entry wins over the instruction in ir
    assign exec     = (state == st_run) && !take_irq;

    // Whole-word decode
    assign is_load  = exec && (ir == op_load_key);
    assign is_store = exec && (ir == op_store_con);
    assign is_mret  = exec && (ir == op_mret);

    // Ack in the redirect cycle
    assign irq_ack = take_irq;

    // Bus strobes last exactly the issue cycle
    assign bus_read_enable  = is_load;
    assign bus_write_enable = is_store;

    always_comb begin
        bus_address = ram_base;
        if (is_load) begin
            bus_address = key_addr;
        end else if (is_store) begin
            bus_address = console_addr;
        end
    end

    // Store drives x5 onto the bus
    assign bus_write_data = is_store ? regs[key_reg] : '0;

    // Control path
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pc         <= ram_base;
            ir         <= op_nop;
            state      <= st_run;
            in_routine <= 1'b0;
            heartbeat  <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;

            // ir freezes during st_load so the next word is not skipped
            if (state != st_load) begin
                ir <= instr;
            end

            unique case (state)
                st_run: begin
                    if (take_irq) begin
                        // Vector to the routine in ROM
                        pc         <= rom_base;
                        in_routine <= 1'b1;
                        state      <= st_flush1;
                    end else if (is_mret) begin
                        pc         <= mepc;
                        in_routine <= 1'b0;
                        state      <= st_flush1;
                    end else if (is_load) begin
                        // pc holds one cycle to line up with the frozen ir
                        state <= st_load;
                    end else begin
                        pc <= pc_next;
                    end
                end
                // Two stale fetches dropped after a redirect
                st_flush1: begin
                    pc    <= pc_next;
                    state <= st_flush2;
                end
                st_flush2: begin
                    pc    <= pc_next;
                    state <= st_run;
                end
                // Read data arrives this cycle
                st_load: begin
                    pc    <= pc_next;
                    state <= st_run;
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    // Data path registers
    always_ff @(posedge CLOCK_50) begin
        if (take_irq) begin
            mepc <= pc;
        end
        // Load capture into x5
        if (state == st_load) begin
            regs[key_reg] <= bus_read_data;
        end
    end

endmodule

/* rtl/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric
    import soc_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  xlen_t pc,
    input  xlen_t bus_address,
    input  xlen_t bus_write_data,
    input  logic  bus_read_enable,
    input  logic  bus_write_enable,
    input  key_t  key_data,
    output word_t instr,
    output xlen_t bus_read_data,
    output key_t  console_data,
    output logic  console_valid
);

    // Shared ROM and RAM words
    word_t mem [mem_words];

    logic [mem_aw-1:0] fetch_idx;
    logic [mem_aw-1:0] data_idx;

    logic rom_sel;
    logic ram_sel;
    logic key_sel;
    logic con_sel;
    logic con_write;
    logic con_write_d;

    // Image is stored big-endian per word
    function automatic word_t byte_swap(input word_t w);
        byte_swap = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    initial begin
        $readmemh(prog_file, mem);
    end

    // Word index from byte address
    assign fetch_idx = pc[mem_aw+1:2];
    assign data_idx  = bus_address[mem_aw+1:2];

    // Region decode
    assign rom_sel = (bus_address >= rom_base) && (bus_address < rom_base + rom_size);
    assign ram_sel = (bus_address >= ram_base) && (bus_address < ram_base + ram_size);
    assign key_sel = (bus_address == key_addr);
    assign con_sel = (bus_address == console_addr);

    // Instruction port, one cycle latency
    always_ff @(posedge CLOCK_50) begin
        instr <= byte_swap(mem[fetch_idx]);
    end

    // Data port
    always_ff @(posedge CLOCK_50) begin
        // ROM is read-only
        if (bus_write_enable && ram_sel) begin
            mem[data_idx] <= bus_write_data[31:0];
        end
        // Registered read mux, holds when idle
        if (bus_read_enable) begin
            if (key_sel) begin
                bus_read_data <= xlen_t'(key_data);
            end else if (rom_sel || ram_sel) begin
                bus_read_data <= xlen_t'(mem[data_idx]);
            end
        end
    end

    // Console port write
    assign con_write = bus_write_enable && con_sel;

    // Rising edge of the write gives one pulse a cycle later
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            con_write_d   <= 1'b0;
            console_valid <= 1'b0;
        end else begin
            con_write_d   <= con_write;
            console_valid <= con_write && !con_write_d;
        end
    end

    // Low byte lines up with console_valid
    always_ff @(posedge CLOCK_50) begin
        if (con_write) begin
            console_data <= bus_write_data[7:0];
        end
    end

endmodule

/* rtl/key_irq_ctrl.sv */
`timescale 1ns/1ps

module key_irq_ctrl
    import soc_pkg::*;
(
    input  logic CLOCK_50,
    input  logic KEY0,
    input  key_t key_code,
    input  logic key_down,
    input  logic irq_ack,
    output vec_t irq_vector,
    output key_t key_data,
    output logic irq_led
);

    logic key_down_d;
    // Set by an accepted press until the key is released
    logic handled;
    logic press;

    // New nonzero press, nothing held and nothing pending
    assign press = key_down && !key_down_d && (key_code != '0)
                   && !handled && (irq_vector == '0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_down_d <= 1'b0;
            handled    <= 1'b0;
            irq_vector <= '0;
            key_data   <= '0;
            irq_led    <= 1'b0;
        end else begin
            key_down_d <= key_down;
            if (press) begin
                key_data   <= key_code;
                irq_vector <= key_vec;
                irq_led    <= 1'b1;
                handled    <= 1'b1;
            end
            // Request is sent once, dropped on ack
            if (irq_ack && (irq_vector != '0)) begin
                irq_vector <= '0;
                irq_led    <= 1'b0;
            end
            // Release re-arms capture
            if (!key_down) begin
                handled <= 1'b0;
            end
        end
    end

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

    // Plain vector types
    typedef logic [31:0] word_t;
    typedef logic [63:0] xlen_t;
    typedef logic [7:0]  key_t;
    typedef logic [3:0]  vec_t;

    // Word memory shared by ROM and RAM
    localparam int mem_words = 1024;
    localparam int mem_aw    = $clog2(mem_words);
    localparam string prog_file = "prog.hex";

    // Memory map, byte addresses
    localparam xlen_t rom_base = 64'd0;
    localparam xlen_t rom_size = 64'd256;
    localparam xlen_t ram_base = 64'd256;
    localparam xlen_t ram_size = 64'd3072;
    // I/O ports sit right after RAM
    localparam xlen_t key_addr     = ram_base + ram_size;
    localparam xlen_t console_addr = key_addr + 64'd4;

    // Custom opcodes, compared as whole words
    localparam word_t op_load_key  = 32'hFFFF_FFFF;
    localparam word_t op_store_con = 32'hFFFF_FF7F;
    localparam word_t op_mret      = 32'h0000_0000;
    // Not decoded by the core, so it runs as a no-op
    localparam word_t op_nop       = 32'h0000_0013;

    // Key interrupt vector number
    localparam vec_t key_vec = 4'd1;
    // Destination register of the key load
    localparam int key_reg = 5;

    // Core execute FSM
    typedef enum logic [1:0] {
        st_run,
        st_flush1,
        st_flush2,
        st_load
    } core_state_t;

endpackage
